//--- src/alu_pkg.sv
// alu package: operation codes, shift amount type and the per-request control word
package alu_pkg;

	// default sizes, overridden through the top level parameters
	localparam int DEF_DATA_W = 32; // operand width
	localparam int DEF_BLOCK_W = 4; // bits per lookahead block

	localparam int SHAMT_W = 2; // shifts of 0 to 3 places

	// operation codes, one per cycle on op_start
	typedef enum logic [3:0]
	{
		op_nop = 4'd0, // result is zero
		op_not_a = 4'd1,
		op_not_b = 4'd2,
		op_and = 4'd3,
		op_or = 4'd4,
		op_xor = 4'd5,
		op_xnor = 4'd6,
		op_lsl_a = 4'd7, // sign-extended, then shifted left
		op_lsl_b = 4'd8,
		op_lsr_a = 4'd9, // zero fill, high word zero
		op_lsr_b = 4'd10,
		op_asr_a = 4'd11, // sign fill, high word is the sign
		op_asr_b = 4'd12,
		op_add = 4'd13, // 64-bit sign-extended sum
		op_sub = 4'd14,
		op_mul = 4'd15 // reserved, result is zero
	} alu_op_e;

	typedef logic [SHAMT_W-1:0] shamt_t;

	// control that goes along with every request, 6 bits
	typedef struct packed
	{
		alu_op_e op;
		shamt_t shamt;
	} alu_ctrl_t;

endpackage

//--- src/operand_prep.sv
// operand preparation: widens both operands for the adder chain, negates B for subtraction
`timescale 1ns/1ns

module operand_prep
#(
	parameter int DATA_W = alu_pkg::DEF_DATA_W
)
(
	input alu_pkg::alu_ctrl_t ctrl,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	output logic [2*DATA_W-1:0] wide_a,
	output logic [2*DATA_W-1:0] wide_b,
	output logic carry_in
);
	import alu_pkg::*;

	logic is_sub;
	logic [2*DATA_W-1:0] ext_b;

	assign is_sub = (ctrl.op == op_sub);

	// both operands are signed, so the high half is the sign bit repeated
	assign wide_a = {{DATA_W{a[DATA_W-1]}}, a};
	assign ext_b = {{DATA_W{b[DATA_W-1]}}, b};

	// a - b = a + ~b + 1
	assign wide_b = is_sub ? ~ext_b : ext_b;
	assign carry_in = is_sub; // the +1 of the two's complement

endmodule

//--- src/cla_block.sv
// carry-lookahead block: one slice of the wide adder, carries formed from generate and propagate
`timescale 1ns/1ns

module cla_block
#(
	parameter int BLOCK_W = alu_pkg::DEF_BLOCK_W
)
(
	input logic [BLOCK_W-1:0] a_slice,
	input logic [BLOCK_W-1:0] b_slice,
	input logic carry_prev,
	output logic [BLOCK_W-1:0] sum_slice,
	output logic carry_next
);

	logic [BLOCK_W-1:0] g; // generate
	logic [BLOCK_W-1:0] p; // propagate
	logic [BLOCK_W:0] c; // c[i] is the carry into bit i

	// carry into bit idx as a flat sum of products
	// no term depends on another carry, so nothing ripples
	function automatic logic carry_at(input logic [BLOCK_W-1:0] gen,
		input logic [BLOCK_W-1:0] prop, input logic cin, input int idx);
		logic acc;
		logic term;
		acc = 1'b0;
		for (int j = 0; j < idx; j++)
		begin
			term = gen[j]; // generated at j, passed through j+1 .. idx-1
			for (int k = j + 1; k < idx; k++)
				term = term & prop[k];
			acc = acc | term;
		end
		term = cin; // block carry in, passed through every bit below idx
		for (int k = 0; k < idx; k++)
			term = term & prop[k];
		return acc | term;
	endfunction

	assign g = a_slice & b_slice;
	assign p = a_slice ^ b_slice;

	for (genvar i = 0; i <= BLOCK_W; i++)
	begin : g_carry
		assign c[i] = carry_at(g, p, carry_prev, i);
	end

	assign sum_slice = p ^ c[BLOCK_W-1:0];
	assign carry_next = c[BLOCK_W]; // into the next block

endmodule

//--- src/alu_shifter.sv
// shifter: logical left, logical right and arithmetic right of A or B by 0 to 3 places
`timescale 1ns/1ns

module alu_shifter
#(
	parameter int DATA_W = alu_pkg::DEF_DATA_W
)
(
	input alu_pkg::alu_ctrl_t ctrl,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] shift_hi,
	output logic [DATA_W-1:0] shift_lo
);
	import alu_pkg::*;

	logic [DATA_W-1:0] src; // operand picked by the opcode
	logic [2*DATA_W-1:0] ext_src;
	logic [2*DATA_W-1:0] lsl_res;
	logic [DATA_W-1:0] lsr_res;
	logic [DATA_W-1:0] asr_res;

	always_comb
	begin
		case (ctrl.op)
			op_lsl_b, op_lsr_b, op_asr_b: src = b;
			default: src = a;
		endcase
	end

	// left shift works on the sign-extended value, so bits shifted out land in the high word
	assign ext_src = {{DATA_W{src[DATA_W-1]}}, src};
	assign lsl_res = ext_src << ctrl.shamt;

	assign lsr_res = src >> ctrl.shamt; // zeros in from the top
	assign asr_res = $signed(src) >>> ctrl.shamt; // sign in from the top

	always_comb
	begin
		case (ctrl.op)
			op_lsl_a, op_lsl_b:
			begin
				shift_hi = lsl_res[2*DATA_W-1:DATA_W];
				shift_lo = lsl_res[DATA_W-1:0];
			end
			op_lsr_a, op_lsr_b:
			begin
				shift_hi = '0;
				shift_lo = lsr_res;
			end
			op_asr_a, op_asr_b:
			begin
				shift_hi = {DATA_W{asr_res[DATA_W-1]}}; // sign of the low word
				shift_lo = asr_res;
			end
			default:
			begin
				// not a shift, the result stage ignores these
				shift_hi = '0;
				shift_lo = '0;
			end
		endcase
	end

endmodule

//--- src/result_stage.sv
// result stage: logic operations, result select by opcode, result and op_done registers
`timescale 1ns/1ns

module result_stage
#(
	parameter int DATA_W = alu_pkg::DEF_DATA_W
)
(
	input logic clk,
	input logic rst_n,
	input logic op_start,
	input alu_pkg::alu_ctrl_t ctrl,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	input logic [2*DATA_W-1:0] sum,
	input logic [DATA_W-1:0] shift_hi,
	input logic [DATA_W-1:0] shift_lo,
	output logic op_done,
	output logic [DATA_W-1:0] result_hi,
	output logic [DATA_W-1:0] result_lo
);
	import alu_pkg::*;

	typedef struct packed
	{
		logic [DATA_W-1:0] hi;
		logic [DATA_W-1:0] lo;
	} word_pair_t;

	logic [DATA_W-1:0] logic_lo;
	word_pair_t next_res;
	word_pair_t res_q;

	always_comb
	begin
		case (ctrl.op)
			op_not_a: logic_lo = ~a;
			op_not_b: logic_lo = ~b;
			op_and: logic_lo = a & b;
			op_or: logic_lo = a | b;
			op_xor: logic_lo = a ^ b;
			op_xnor: logic_lo = ~(a ^ b);
			default: logic_lo = '0;
		endcase
	end

	always_comb
	begin
		case (ctrl.op)
			op_not_a, op_not_b, op_and, op_or, op_xor, op_xnor:
			begin
				next_res.hi = {DATA_W{logic_lo[DATA_W-1]}}; // sign of the low word
				next_res.lo = logic_lo;
			end
			op_lsl_a, op_lsl_b, op_lsr_a, op_lsr_b, op_asr_a, op_asr_b:
			begin
				next_res.hi = shift_hi;
				next_res.lo = shift_lo;
			end
			op_add, op_sub: next_res = sum; // already 64-bit signed
			default: next_res = '0; // nop and the reserved mul code
		endcase
	end

	// one request per cycle, result one edge later
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			res_q <= '0;
			op_done <= 1'b0;
		end
		else
		begin
			op_done <= op_start; // single-cycle pulse per strobe
			if (op_start)
				res_q <= next_res; // holds otherwise
		end
	end

	assign result_hi = res_q.hi;
	assign result_lo = res_q.lo;

endmodule

//--- src/alu_top.sv
// alu top level: operand preparation, lookahead adder chain, shifter and registered result
`timescale 1ns/1ns

module alu_top
#(
	parameter int DATA_W = alu_pkg::DEF_DATA_W,
	parameter int BLOCK_W = alu_pkg::DEF_BLOCK_W
)
(
	input logic clk,
	input logic rst_n,
	input logic op_start,
	input alu_pkg::alu_ctrl_t ctrl,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	output logic op_done,
	output logic [DATA_W-1:0] result_hi,
	output logic [DATA_W-1:0] result_lo
);

	localparam int NUM_BLOCKS = 2 * DATA_W / BLOCK_W; // blocks across the 64-bit sum

	logic [2*DATA_W-1:0] wide_a;
	logic [2*DATA_W-1:0] wide_b;
	logic [2*DATA_W-1:0] sum;
	logic [NUM_BLOCKS:0] carry; // carry[0] is the chain input, the top one is dropped
	logic [DATA_W-1:0] shift_hi;
	logic [DATA_W-1:0] shift_lo;

	operand_prep #(.DATA_W(DATA_W)) operand_prep_i
	(
		.ctrl(ctrl),
		.a(a),
		.b(b),
		.wide_a(wide_a),
		.wide_b(wide_b),
		.carry_in(carry[0])
	);

	// sum is taken modulo 2^64
	for (genvar i = 0; i < NUM_BLOCKS; i++)
	begin : g_cla
		cla_block #(.BLOCK_W(BLOCK_W)) cla_block_i
		(
			.a_slice(wide_a[i*BLOCK_W +: BLOCK_W]),
			.b_slice(wide_b[i*BLOCK_W +: BLOCK_W]),
			.carry_prev(carry[i]),
			.sum_slice(sum[i*BLOCK_W +: BLOCK_W]),
			.carry_next(carry[i+1])
		);
	end

	alu_shifter #(.DATA_W(DATA_W)) alu_shifter_i
	(
		.ctrl(ctrl),
		.a(a),
		.b(b),
		.shift_hi(shift_hi),
		.shift_lo(shift_lo)
	);

	result_stage #(.DATA_W(DATA_W)) result_stage_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.op_start(op_start),
		.ctrl(ctrl),
		.a(a),
		.b(b),
		.sum(sum),
		.shift_hi(shift_hi),
		.shift_lo(shift_lo),
		.op_done(op_done),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

endmodule

//--- verification/alu_tb.sv
// alu testbench: directed table, back-to-back burst and random operations against a model
`timescale 1ns/1ns

module alu_tb;
	import alu_pkg::*;

	localparam int DATA_W = DEF_DATA_W;
	localparam int DONE_TIMEOUT = 20; // cycles to wait for op_done
	localparam int NUM_RANDOM = 200;
	localparam int NUM_BURST = 8;

	// one request with its expected result words
	typedef struct packed
	{
		alu_ctrl_t ctrl;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] exp_hi;
		logic [DATA_W-1:0] exp_lo;
	} vec_t;

	logic clk;
	logic rst_n;
	logic op_start;
	alu_ctrl_t ctrl;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic op_done;
	logic [DATA_W-1:0] result_hi;
	logic [DATA_W-1:0] result_lo;

	vec_t table_q[$];
	vec_t burst_q[$];
	alu_op_e burst_ops [NUM_BURST] = '{op_add, op_xor, op_lsl_a, op_sub,
		op_asr_b, op_and, op_lsr_b, op_not_a};

	alu_top alu_top_i
	(
		.clk(clk),
		.rst_n(rst_n),
		.op_start(op_start),
		.ctrl(ctrl),
		.a(a),
		.b(b),
		.op_done(op_done),
		.result_hi(result_hi),
		.result_lo(result_lo)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_result(input alu_op_e op, input logic [DATA_W-1:0] exp_hi,
		input logic [DATA_W-1:0] exp_lo);
		if (result_hi !== exp_hi || result_lo !== exp_lo)
			abort_run($sformatf("Error at %0t: %s gave %h_%h, expected %h_%h", $time,
				op.name(), result_hi, result_lo, exp_hi, exp_lo));
	endtask

	task automatic check_done(input alu_op_e op, input logic exp_done);
		if (op_done !== exp_done)
			abort_run($sformatf("Error at %0t: %s op_done is %b, expected %b", $time,
				op.name(), op_done, exp_done));
	endtask

	task automatic wait_for_done(input alu_op_e op);
		int cycles;
		cycles = 0;
		while (!op_done)
		begin
			if (cycles == DONE_TIMEOUT)
				abort_run($sformatf("op_done never came within %0d cycles after a %s request",
					DONE_TIMEOUT, op.name()));
			else
			begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// expected 64-bit result, worked out in signed 64-bit arithmetic
	function automatic logic [2*DATA_W-1:0] model_result(input alu_ctrl_t c,
		input logic [DATA_W-1:0] op_a, input logic [DATA_W-1:0] op_b);
		logic [DATA_W-1:0] src;
		logic [DATA_W-1:0] lo;
		longint sa;
		longint sb;
		logic [2*DATA_W-1:0] res;
		src = (c.op == op_lsl_b || c.op == op_lsr_b || c.op == op_asr_b) ? op_b : op_a;
		sa = longint'(signed'(op_a));
		sb = longint'(signed'(op_b));
		lo = '0;
		case (c.op)
			op_not_a: lo = ~op_a;
			op_not_b: lo = ~op_b;
			op_and: lo = op_a & op_b;
			op_or: lo = op_a | op_b;
			op_xor: lo = op_a ^ op_b;
			op_xnor: lo = ~(op_a ^ op_b);
			default: lo = '0;
		endcase
		case (c.op)
			op_not_a, op_not_b, op_and, op_or, op_xor, op_xnor:
				res = longint'(signed'(lo)); // high word follows bit 31
			op_lsl_a, op_lsl_b:
				res = longint'(signed'(src)) * (longint'(1) << c.shamt);
			op_lsr_a, op_lsr_b:
				res = {{DATA_W{1'b0}}, src / (32'd1 << c.shamt)};
			op_asr_a, op_asr_b:
			begin
				lo = src;
				repeat (c.shamt)
					lo = {lo[DATA_W-1], lo[DATA_W-1:1]}; // one place, sign kept
				res = longint'(signed'(lo));
			end
			op_add: res = sa + sb;
			op_sub: res = sa - sb;
			default: res = '0; // nop and mul
		endcase
		return res;
	endfunction

	function automatic vec_t build_vec(input alu_ctrl_t c, input logic [DATA_W-1:0] op_a,
		input logic [DATA_W-1:0] op_b, input logic [DATA_W-1:0] hi,
		input logic [DATA_W-1:0] lo);
		vec_t v;
		v.ctrl = c;
		v.a = op_a;
		v.b = op_b;
		v.exp_hi = hi;
		v.exp_lo = lo;
		return v;
	endfunction

	task automatic add_entry(input alu_op_e op, input shamt_t sh, input logic [DATA_W-1:0] op_a,
		input logic [DATA_W-1:0] op_b, input logic [DATA_W-1:0] hi,
		input logic [DATA_W-1:0] lo);
		alu_ctrl_t c;
		c.op = op;
		c.shamt = sh;
		table_q.push_back(build_vec(c, op_a, op_b, hi, lo));
	endtask

	// expected words worked out by hand
	task automatic load_table();
		add_entry(op_not_a, 2'd0, 32'h000000FF, 32'h00000000, 32'hFFFFFFFF, 32'hFFFFFF00);
		add_entry(op_not_b, 2'd0, 32'h00000000, 32'h80000000, 32'h00000000, 32'h7FFFFFFF);
		add_entry(op_and, 2'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'hFFFFFFFF, 32'hF000F000);
		add_entry(op_or, 2'd0, 32'h12340000, 32'h00005678, 32'h00000000, 32'h12345678);
		add_entry(op_xor, 2'd0, 32'hAAAAAAAA, 32'h55555555, 32'hFFFFFFFF, 32'hFFFFFFFF);
		add_entry(op_xnor, 2'd0, 32'hAAAAAAAA, 32'h55555555, 32'h00000000, 32'h00000000);
		add_entry(op_lsl_a, 2'd0, 32'h80000001, 32'h00000000, 32'hFFFFFFFF, 32'h80000001);
		add_entry(op_lsl_a, 2'd1, 32'h80000001, 32'h00000000, 32'hFFFFFFFF, 32'h00000002);
		add_entry(op_lsl_a, 2'd3, 32'hF0000000, 32'h00000000, 32'hFFFFFFFF, 32'h80000000);
		add_entry(op_lsl_b, 2'd3, 32'h00000000, 32'h40000000, 32'h00000002, 32'h00000000);
		add_entry(op_lsl_b, 2'd2, 32'h00000000, 32'hC0000003, 32'hFFFFFFFF, 32'h0000000C);
		add_entry(op_lsr_a, 2'd1, 32'h80000000, 32'h00000000, 32'h00000000, 32'h40000000);
		add_entry(op_lsr_a, 2'd3, 32'hFFFFFFF8, 32'h00000000, 32'h00000000, 32'h1FFFFFFF);
		add_entry(op_lsr_b, 2'd2, 32'h00000000, 32'h00000010, 32'h00000000, 32'h00000004);
		add_entry(op_lsr_b, 2'd0, 32'h00000000, 32'h87654321, 32'h00000000, 32'h87654321);
		add_entry(op_asr_a, 2'd2, 32'h80000000, 32'h00000000, 32'hFFFFFFFF, 32'hE0000000);
		add_entry(op_asr_a, 2'd3, 32'h7FFFFFF0, 32'h00000000, 32'h00000000, 32'h0FFFFFFE);
		add_entry(op_asr_b, 2'd1, 32'h00000000, 32'hFFFFFFFE, 32'hFFFFFFFF, 32'hFFFFFFFF);
		add_entry(op_asr_b, 2'd0, 32'h00000000, 32'h90000000, 32'hFFFFFFFF, 32'h90000000);
		add_entry(op_add, 2'd0, 32'h00000005, 32'h00000007, 32'h00000000, 32'h0000000C);
		add_entry(op_add, 2'd0, 32'h7FFFFFFF, 32'h00000001, 32'h00000000, 32'h80000000);
		add_entry(op_add, 2'd0, 32'h80000000, 32'h80000000, 32'hFFFFFFFF, 32'h00000000);
		add_entry(op_add, 2'd0, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 32'h00000000);
		add_entry(op_sub, 2'd0, 32'h00000003, 32'h00000005, 32'hFFFFFFFF, 32'hFFFFFFFE);
		add_entry(op_sub, 2'd0, 32'h80000000, 32'h00000001, 32'hFFFFFFFF, 32'h7FFFFFFF);
		add_entry(op_sub, 2'd0, 32'h7FFFFFFF, 32'hFFFFFFFF, 32'h00000000, 32'h80000000);
		add_entry(op_nop, 2'd1, 32'h00001234, 32'h00005678, 32'h00000000, 32'h00000000);
		add_entry(op_mul, 2'd0, 32'h00000003, 32'h00000004, 32'h00000000, 32'h00000000);
	endtask

	// one request, then wait for its pulse and compare
	task automatic run_op(input vec_t v);
		@(negedge clk);
		check_done(v.ctrl.op, 1'b0); // previous pulse is over
		op_start = 1'b1;
		ctrl = v.ctrl;
		a = v.a;
		b = v.b;
		@(negedge clk);
		op_start = 1'b0;
		wait_for_done(v.ctrl.op);
		check_result(v.ctrl.op, v.exp_hi, v.exp_lo);
	endtask

	initial
	begin
		alu_ctrl_t rc;
		logic [3:0] op_bits;
		logic [DATA_W-1:0] ra;
		logic [DATA_W-1:0] rb;
		logic [2*DATA_W-1:0] m;

		rst_n = 1'b0;
		op_start = 1'b0;
		ctrl = '{op: op_nop, shamt: '0};
		a = '0;
		b = '0;
		void'($urandom(36));
		load_table();

		// four rising edges under reset, released on the next falling edge
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// idle after reset
		repeat (2)
		begin
			@(negedge clk);
			check_done(op_nop, 1'b0);
			check_result(op_nop, '0, '0);
		end

		foreach (table_q[i])
			run_op(table_q[i]);

		// back-to-back requests, one per cycle
		for (int i = 0; i < NUM_BURST; i++)
		begin
			rc.op = burst_ops[i];
			rc.shamt = shamt_t'($urandom_range(3, 0));
			ra = $urandom();
			rb = $urandom();
			m = model_result(rc, ra, rb);
			burst_q.push_back(build_vec(rc, ra, rb, m[2*DATA_W-1:DATA_W], m[DATA_W-1:0]));
		end
		@(negedge clk);
		check_done(op_nop, 1'b0);
		for (int i = 0; i <= NUM_BURST; i++)
		begin
			if (i > 0)
			begin
				check_done(burst_q[i-1].ctrl.op, 1'b1);
				check_result(burst_q[i-1].ctrl.op, burst_q[i-1].exp_hi, burst_q[i-1].exp_lo);
			end
			if (i < NUM_BURST)
			begin
				op_start = 1'b1;
				ctrl = burst_q[i].ctrl;
				a = burst_q[i].a;
				b = burst_q[i].b;
			end
			else
			begin
				op_start = 1'b0;
				a = ~a; // inputs move, result must not
				b = ~b;
			end
			@(negedge clk);
		end
		repeat (2)
		begin
			check_done(burst_q[NUM_BURST-1].ctrl.op, 1'b0);
			check_result(burst_q[NUM_BURST-1].ctrl.op, burst_q[NUM_BURST-1].exp_hi,
				burst_q[NUM_BURST-1].exp_lo);
			@(negedge clk);
		end

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			op_bits = 4'($urandom_range(15, 0));
			rc.op = alu_op_e'(op_bits);
			rc.shamt = shamt_t'($urandom_range(3, 0));
			ra = $urandom();
			rb = $urandom();
			m = model_result(rc, ra, rb);
			run_op(build_vec(rc, ra, rb, m[2*DATA_W-1:DATA_W], m[DATA_W-1:0]));
		end

		$display("All tests passed");
		$finish;
	end

endmodule

//--- all.f
src/alu_pkg.sv
src/operand_prep.sv
src/cla_block.sv
src/alu_shifter.sv
src/result_stage.sv
src/alu_top.sv
verification/alu_tb.sv

//--- Makefile
# Verilator build and run of the ALU testbench

VERILATOR ?= verilator
TOP ?= alu_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing -j $(JOBS)
LINT_FLAGS ?= -Wall

.PHONY: run build lint clean

run: build
	./$(OBJ_DIR)/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
